// File: cpu.f
cpu_pkg.sv
inst_if.sv
prog_ram.sv
fetch_stage.sv
exec_stage.sv
data_ram.sv
cpu.sv
cpu_chk.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f cpu.f --top-module tb_cpu

out=$(./obj_dir/Vtb_cpu 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
else
  exit 1
fi

// File: tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu import cpu_pkg::*; ();

  localparam int NUM_ROWS      = 12;
  localparam int PROG_WORDS    = 20;
  localparam int STORE_TIMEOUT = 200; // cycles allowed for each store
  localparam int IDLE_WINDOW   = 40;  // cycles watched for a stray store

  typedef struct packed {
    logic  minus;
    word_t a;
    word_t b;
    addr_t d;
    word_t result; // (a op b) mod 2^16
  } row_t;

  logic  clka;
  logic  rst;
  logic  run;
  logic  prog_we;
  addr_t prog_addr;
  word_t prog_data;
  logic  store_valid;
  addr_t store_addr;
  word_t store_data;

  row_t  rows [NUM_ROWS];
  word_t prog_img [PROG_WORDS];
  int    checks;
  int    errors;

  cpu dut0 (
    .clka        (clka),
    .rst         (rst),
    .run         (run),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  initial clka = 1'b0;
  always #50 clka = ~clka;

  function automatic word_t apply_op(input logic minus, input word_t a, input word_t b);
    if (minus) begin
      return a - b;
    end
    return a + b;
  endfunction

  function automatic row_t make_row(input logic minus, input word_t a, input word_t b,
                                    input addr_t d, input word_t result);
    row_t r;
    r.minus  = minus;
    r.a      = a;
    r.b      = b;
    r.d      = d;
    r.result = result;
    return r;
  endfunction

  // first word of an instruction, register number in the low nibble
  function automatic word_t inst_word(input op_t op, input int r);
    return {op, 4'h0, reg_sel_t'(r)};
  endfunction

  task automatic fill_table();
    logic  minus;
    word_t a;
    word_t b;
    addr_t d;
    rows[0] = make_row(1'b0, 16'h0000, 16'h0000, 10'h000, 16'h0000); // all zero
    rows[1] = make_row(1'b0, 16'hFFFF, 16'h0001, 10'h100, 16'h0000); // wraps up
    rows[2] = make_row(1'b1, 16'h0000, 16'h0001, 10'h3FD, 16'hFFFF); // wraps down, top of ram
    rows[3] = make_row(1'b0, 16'hFFFF, 16'hFFFF, 10'h2A0, 16'hFFFE);
    rows[4] = make_row(1'b1, 16'h1234, 16'h1234, 10'h005, 16'h0000);
    rows[5] = make_row(1'b0, 16'h7FFF, 16'h8000, 10'h3F0, 16'hFFFF); // largest value
    for (int i = 6; i < NUM_ROWS; i++) begin
      minus   = 1'($urandom % 2);
      a       = word_t'($urandom);
      b       = word_t'($urandom);
      d       = addr_t'($urandom % 1022); // d+2 must stay inside the ram
      rows[i] = make_row(minus, a, b, d, apply_op(minus, a, b));
    end
  endtask

  task automatic build_program(input row_t r);
    prog_img[0]  = inst_word(OP_NUM2REG, 1);
    prog_img[1]  = r.a;
    prog_img[2]  = inst_word(r.minus ? OP_REG_MINUS : OP_REG_PLUS, 1);
    prog_img[3]  = r.b;
    prog_img[4]  = inst_word(OP_NUM2REG, 3);
    prog_img[5]  = 16'h5555;
    prog_img[6]  = inst_word(OP_JMP, 0);
    prog_img[7]  = 16'd10; // over the next instruction
    prog_img[8]  = inst_word(OP_NUM2REG, 3);
    prog_img[9]  = 16'hAAAA; // must never execute
    prog_img[10] = inst_word(OP_REG2RAM, 1);
    prog_img[11] = word_t'(r.d);
    prog_img[12] = inst_word(OP_RAM2REG, 2);
    prog_img[13] = word_t'(r.d);
    prog_img[14] = inst_word(OP_REG2RAM, 2);
    prog_img[15] = word_t'(r.d) + 16'd1;
    prog_img[16] = inst_word(OP_REG2RAM, 3);
    prog_img[17] = word_t'(r.d) + 16'd2;
    prog_img[18] = inst_word(OP_JMP, 0);
    prog_img[19] = 16'd18; // spin here
  endtask

  task automatic check_value(input string sig, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s expected %h got %h", $time, sig, exp, got);
      errors++;
    end
  endtask

  task automatic check_quiet(input int idx);
    checks++;
    assert (store_valid === 1'b0) else begin
      $display("row %0d: store_valid went high at %0t while run was low", idx, $time);
      errors++;
    end
  endtask

  task automatic reset_dut();
    @(negedge clka);
    rst     = 1'b0;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (2) @(negedge clka);
    rst = 1'b1;
  endtask

  task automatic load_program(input int idx);
    for (int i = 0; i < PROG_WORDS; i++) begin
      @(negedge clka);
      check_quiet(idx);
      prog_we   = 1'b1;
      prog_addr = addr_t'(i);
      prog_data = prog_img[i];
    end
    @(negedge clka);
    check_quiet(idx);
    prog_we = 1'b0;
  endtask

  task automatic wait_store(output logic found, output addr_t addr, output word_t data);
    int cycles;
    found  = 1'b0;
    addr   = '0;
    data   = '0;
    cycles = 0;
    while (!found && cycles < STORE_TIMEOUT) begin
      @(negedge clka);
      cycles++;
      if (store_valid === 1'b1) begin
        found = 1'b1;
        addr  = store_addr;
        data  = store_data;
      end
    end
  endtask

  task automatic run_row(input int idx);
    row_t  r;
    logic  found;
    logic  lost;
    addr_t got_addr;
    word_t got_data;
    int    errors_before;
    r             = rows[idx];
    errors_before = errors;
    lost          = 1'b0;
    build_program(r);
    reset_dut();
    load_program(idx);
    @(negedge clka);
    run = 1'b1;
    for (int n = 0; n < 3 && !lost; n++) begin
      wait_store(found, got_addr, got_data);
      checks++;
      assert (found) else begin
        $display("row %0d: store %0d did not arrive within %0d cycles", idx, n, STORE_TIMEOUT);
        errors++;
        lost = 1'b1;
      end
      if (found) begin
        check_value("store_addr", word_t'(got_addr), word_t'(r.d) + word_t'(n));
        if (n == 0) begin
          check_value("store_data", got_data, r.result);
        end else if (n == 1) begin
          check_value("store_data", got_data, r.result); // load returns the stored word
        end else begin
          check_value("store_data", got_data, 16'h5555);
        end
      end
    end
    if (!lost) begin
      for (int n = 0; n < IDLE_WINDOW; n++) begin
        @(negedge clka);
        checks++;
        assert (store_valid !== 1'b1) else begin
          $display("row %0d: extra store to %h at %0t", idx, store_addr, $time);
          errors++;
        end
      end
    end
    run = 1'b0;
    $display("row %0d %s a=%h b=%h d=%h: %s", idx, r.minus ? "minus" : "plus", r.a, r.b,
             r.d, (errors == errors_before) ? "ok" : "error");
  endtask

  initial begin
    rst       = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    checks    = 0;
    errors    = 0;
    void'($urandom(28));
    fill_table();
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("rows=%0d checks=%0d errors=%0d", NUM_ROWS, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cpu_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_chk import cpu_pkg::*; (
  input wire                clka,
  input wire                rst,
  input wire                inst_valid,
  input wire                credit_ret,
  input wire [CREDIT_W-1:0] count,
  input wire                store_valid
);

  logic [CREDIT_W-1:0] credits; // mirror of the fetch credit counter, rebuilt from the link

  always_ff @(posedge clka) begin
    if (!rst) begin
      credits <= CREDIT_W'(INST_QUEUE_DEPTH);
    end else begin
      credits <= credits - CREDIT_W'(inst_valid) + CREDIT_W'(credit_ret);
    end
  end

  issue_needs_credit: assert property (
    @(posedge clka) disable iff (!rst) inst_valid |-> (credits != '0)
  ) else $error("instruction handed over with no credit left");

  store_quiet_after_reset: assert property (
    @(posedge clka) !rst |=> !store_valid
  ) else $error("store_valid high in the cycle after reset");

  queue_bounded: assert property (
    @(posedge clka) disable iff (!rst) count <= CREDIT_W'(INST_QUEUE_DEPTH)
  ) else $error("instruction queue holds more entries than its depth");

  // a full queue may only take a new entry while one leaves
  queue_no_overflow: assert property (
    @(posedge clka) disable iff (!rst)
      (count == CREDIT_W'(INST_QUEUE_DEPTH)) |-> !(inst_valid && !credit_ret)
  ) else $error("instruction written into a full queue");

endmodule

bind exec_stage cpu_chk chk0 (
  .clka        (clka),
  .rst         (rst),
  .inst_valid  (ifc.inst_valid),
  .credit_ret  (ifc.credit_ret),
  .count       (count),
  .store_valid (store_valid)
);

`default_nettype wire

// File: cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  wire        clka,
  input  wire        rst,
  input  wire        run,
  input  wire        prog_we,
  input  wire addr_t prog_addr,
  input  wire word_t prog_data,
  output logic       store_valid,
  output addr_t      store_addr,
  output word_t      store_data
);

  addr_t prog_raddr;
  word_t prog_rdata;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  inst_if ifc (); // fetch to execute link

  prog_ram prog_ram0 (
    .clka  (clka),
    .we    (prog_we),
    .waddr (prog_addr),
    .wdata (prog_data),
    .raddr (prog_raddr),
    .rdata (prog_rdata)
  );

  fetch_stage fetch0 (
    .clka       (clka),
    .rst        (rst),
    .run        (run),
    .prog_raddr (prog_raddr),
    .prog_rdata (prog_rdata),
    .ifc        (ifc.fetch_mp)
  );

  exec_stage exec0 (
    .clka        (clka),
    .rst         (rst),
    .ifc         (ifc.exec_mp),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_rdata   (mem_rdata),
    .store_valid (store_valid),
    .store_addr  (store_addr),
    .store_data  (store_data)
  );

  data_ram data_ram0 (
    .clka  (clka),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// File: data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram import cpu_pkg::*; (
  input  wire        clka,
  input  wire        we,
  input  wire addr_t addr,
  input  wire word_t wdata,
  output word_t      rdata
);

  word_t mem [1024];

  // single port, read returns the old word during a write
  always_ff @(posedge clka) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// File: exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage import cpu_pkg::*; (
  input  wire        clka,
  input  wire        rst,
  inst_if.exec_mp    ifc,
  output logic       mem_we,
  output addr_t      mem_addr,
  output word_t      mem_wdata,
  input  wire word_t mem_rdata,
  output logic       store_valid,
  output addr_t      store_addr,
  output word_t      store_data
);

  op_t                 q_op      [INST_QUEUE_DEPTH];
  reg_sel_t            q_reg     [INST_QUEUE_DEPTH];
  word_t               q_operand [INST_QUEUE_DEPTH];
  logic                q_epoch   [INST_QUEUE_DEPTH];
  logic [QPTR_W-1:0]   wr_ptr;
  logic [QPTR_W-1:0]   rd_ptr;
  logic [CREDIT_W-1:0] count;      // occupied entries, bounded by the credits

  word_t               regs [NUM_REGS];
  logic                epoch;      // flips on every executed jump
  logic                ld_busy;    // second cycle of a RAM2REG

  op_t                 head_op;
  reg_sel_t            head_reg;
  word_t               head_operand;
  logic                head_valid;
  logic                head_stale; // fetched down a path that was jumped away from
  logic                head_live;

  logic                pop;
  logic                wr_reg;
  word_t               wr_val;
  logic                do_jump;
  logic                do_store;
  logic                ld_start;

  function automatic logic [QPTR_W-1:0] next_ptr(input logic [QPTR_W-1:0] ptr);
    if (ptr == QPTR_W'(INST_QUEUE_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_op      = q_op[rd_ptr];
  assign head_reg     = q_reg[rd_ptr];
  assign head_operand = q_operand[rd_ptr];
  assign head_valid   = (count != '0);
  assign head_stale   = head_valid && (q_epoch[rd_ptr] != epoch);
  assign head_live    = head_valid && !head_stale;

  // everything except the load retires in the cycle it reaches the head
  always_comb begin
    pop      = head_stale; // stale entries are just dropped
    wr_reg   = 1'b0;
    wr_val   = head_operand;
    do_jump  = 1'b0;
    do_store = 1'b0;
    ld_start = 1'b0;
    if (head_live) begin
      case (opcode_t'(head_op))
        OP_NUM2REG: begin
          pop    = 1'b1;
          wr_reg = 1'b1;
        end
        OP_REG_PLUS: begin
          pop    = 1'b1;
          wr_reg = 1'b1;
          wr_val = regs[head_reg] + head_operand; // wraps mod 2^16
        end
        OP_REG_MINUS: begin
          pop    = 1'b1;
          wr_reg = 1'b1;
          wr_val = regs[head_reg] - head_operand;
        end
        OP_JMP: begin
          pop     = 1'b1;
          do_jump = 1'b1;
        end
        OP_REG2RAM: begin
          pop      = 1'b1;
          do_store = 1'b1;
        end
        OP_RAM2REG: begin
          if (ld_busy) begin
            pop    = 1'b1;
            wr_reg = 1'b1;
            wr_val = mem_rdata; // read issued last cycle
          end else begin
            ld_start = 1'b1; // head stays put while the ram answers
          end
        end
        default: pop = 1'b1; // unknown opcode, no effect
      endcase
    end
  end

  always_ff @(posedge clka) begin
    if (ifc.inst_valid) begin
      q_op[wr_ptr]      <= ifc.inst_op;
      q_reg[wr_ptr]     <= ifc.inst_reg;
      q_operand[wr_ptr] <= ifc.inst_operand;
      q_epoch[wr_ptr]   <= ifc.inst_epoch;
    end
  end

  always_ff @(posedge clka) begin
    if (!rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      epoch   <= 1'b0;
      ld_busy <= 1'b0;
    end else begin
      if (ifc.inst_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count <= count + CREDIT_W'(ifc.inst_valid) - CREDIT_W'(pop);
      if (do_jump) begin
        epoch <= ~epoch; // same edge on which fetch flips its copy
      end
      ld_busy <= ld_start;
    end
  end

  always_ff @(posedge clka) begin
    if (wr_reg) begin
      regs[head_reg] <= wr_val;
    end
  end

  assign ifc.credit_ret     = pop;
  assign ifc.redirect_valid = do_jump;
  assign ifc.redirect_pc    = head_operand;

  assign mem_we    = do_store;
  assign mem_addr  = addr_t'(head_operand); // load and store share the head operand
  assign mem_wdata = regs[head_reg];

  assign store_valid = do_store;
  assign store_addr  = mem_addr;
  assign store_data  = mem_wdata;

endmodule

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
  input  wire        clka,
  input  wire        rst,
  input  wire        run,
  output addr_t      prog_raddr,
  input  wire word_t prog_rdata,
  inst_if.fetch_mp   ifc
);

  addr_t               pc;           // next word address to read
  fetch_state_t        state;
  logic [CREDIT_W-1:0] credits;      // free slots in the execute queue
  logic [CREDIT_W-1:0] credits_next;
  logic                epoch;
  op_t                 hi_op;        // first word of the instruction in flight
  reg_sel_t            hi_reg;
  logic                take;         // instruction handed over this cycle
  logic                start_hi;     // enough credit to begin another instruction

  assign prog_raddr = pc;
  assign take       = (state == FETCH_LO);

  // slot used by this cycle's hand-over, plus any slot freed by execute
  assign credits_next = credits - CREDIT_W'(take) + CREDIT_W'(ifc.credit_ret);
  assign start_hi     = run && (credits_next != '0);

  assign ifc.inst_valid   = take;
  assign ifc.inst_op      = hi_op;
  assign ifc.inst_reg     = hi_reg;
  assign ifc.inst_operand = prog_rdata; // operand word arrives in FETCH_LO
  assign ifc.inst_epoch   = epoch;

  always_ff @(posedge clka) begin
    if (!rst) begin
      pc      <= PROG_START;
      state   <= FETCH_IDLE;
      credits <= CREDIT_W'(INST_QUEUE_DEPTH);
      epoch   <= 1'b0;
    end else begin
      credits <= credits_next;
      if (ifc.redirect_valid) begin
        // drop whatever is half fetched and restart at the target
        pc    <= addr_t'(ifc.redirect_pc);
        epoch <= ~epoch;
        state <= FETCH_IDLE;
      end else begin
        case (state)
          FETCH_IDLE, FETCH_LO: begin
            if (start_hi) begin
              pc    <= pc + 1'b1; // first word address goes out now
              state <= FETCH_HI;
            end else begin
              state <= FETCH_IDLE; // pc held, nothing lost
            end
          end
          FETCH_HI: begin
            pc    <= pc + 1'b1; // operand address goes out now
            state <= FETCH_LO;
          end
          default: state <= FETCH_IDLE;
        endcase
      end
    end
  end

  // opcode and register number, bits 7:4 of the register byte are ignored
  always_ff @(posedge clka) begin
    if (state == FETCH_HI) begin
      hi_op  <= prog_rdata[15:8];
      hi_reg <= prog_rdata[3:0];
    end
  end

endmodule

`default_nettype wire

// File: prog_ram.sv
`timescale 1ns/1ps
`default_nettype none

module prog_ram import cpu_pkg::*; (
  input  wire        clka,
  input  wire        we,
  input  wire addr_t waddr,
  input  wire word_t wdata,
  input  wire addr_t raddr,
  output word_t      rdata
);

  word_t mem [1024]; // one instruction takes two words

  // load port, only used while the core is stopped
  always_ff @(posedge clka) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  always_ff @(posedge clka) begin
    rdata <= mem[raddr]; // fetch sees the word one clock later
  end

endmodule

`default_nettype wire

// File: inst_if.sv
`timescale 1ns/1ps
`default_nettype none

interface inst_if import cpu_pkg::*; ();

  logic     inst_valid;   // one instruction handed over this cycle
  op_t      inst_op;
  reg_sel_t inst_reg;
  word_t    inst_operand;
  logic     inst_epoch;   // fetch epoch the instruction was fetched under

  logic     credit_ret;     // one queue slot freed
  logic     redirect_valid; // jump taken in execute
  word_t    redirect_pc;

  modport fetch_mp (
    output inst_valid, inst_op, inst_reg, inst_operand, inst_epoch,
    input  credit_ret, redirect_valid, redirect_pc
  );

  modport exec_mp (
    input  inst_valid, inst_op, inst_reg, inst_operand, inst_epoch,
    output credit_ret, redirect_valid, redirect_pc
  );

endinterface

`default_nettype wire

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [15:0] word_t;   // memory word, register value, operand
  typedef logic [9:0] addr_t;    // word address into either ram
  typedef logic [7:0] op_t;      // opcode byte of the first word
  typedef logic [3:0] reg_sel_t; // low nibble of the register byte

  // instruction word 0 is {opcode, register}, word 1 is the operand
  typedef enum op_t {
    OP_JMP       = 8'd1,
    OP_RAM2REG   = 8'd2,
    OP_REG2RAM   = 8'd3,
    OP_NUM2REG   = 8'd4,
    OP_REG_PLUS  = 8'd5,
    OP_REG_MINUS = 8'd6
  } opcode_t;

  typedef enum logic [1:0] {
    FETCH_IDLE, // waiting for run and a credit
    FETCH_HI,   // opcode/register word returning
    FETCH_LO    // operand word returning, instruction handed over
  } fetch_state_t;

  localparam int NUM_REGS = 16;
  localparam addr_t PROG_START = '0;

  // queue depth doubles as the credit count fetch starts with
  localparam int INST_QUEUE_DEPTH = 4;
  localparam int CREDIT_W = 3;                             // holds 0..INST_QUEUE_DEPTH
  localparam int QPTR_W = $clog2(INST_QUEUE_DEPTH);        // queue pointer width

endpackage

`default_nettype wire
